// File: vrf_pkg.sv
package vrf_pkg;

  // Lane geometry
  localparam int unsigned NrBanks         = 4;
  localparam int unsigned NrOperandQueues = 4;

  // Element and byte-enable widths
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned StrbWidth = 8;
  localparam int unsigned ByteWidth = ElenWidth / StrbWidth;

  // Words per bank and the address split
  localparam int unsigned BankWords    = 64;
  localparam int unsigned VaddrWidth   = 8;
  localparam int unsigned BankSelWidth = $clog2(NrBanks);
  localparam int unsigned RowWidth     = VaddrWidth - BankSelWidth;

  // One vector element
  typedef logic [ElenWidth-1:0] elen_t;

  // One enable bit per element byte
  typedef logic [StrbWidth-1:0] strb_t;

  // Full word address, low bits pick the bank
  typedef logic [VaddrWidth-1:0] vaddr_t;

  // Row inside one bank
  typedef logic [RowWidth-1:0] row_t;

  // Bank select field of an address
  typedef logic [BankSelWidth-1:0] bank_idx_t;

  // Operand queues, the enum value doubles as the queue index
  typedef enum logic [$clog2(NrOperandQueues)-1:0] {
    OPQ_A    = 2'd0,
    OPQ_B    = 2'd1,
    OPQ_C    = 2'd2,
    OPQ_MASK = 2'd3
  } opqueue_e;

  // Read request of one operand queue
  typedef struct packed {
    logic   req;
    vaddr_t addr;
  } opq_req_t;

  // Vector write port
  typedef struct packed {
    logic   req;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } wr_req_t;

  // One bank access, arbiter to register file
  typedef struct packed {
    logic     req;
    logic     wen;
    row_t     row;
    elen_t    wdata;
    strb_t    be;
    opqueue_e tgt;
  } bank_req_t;

endpackage : vrf_pkg

// File: vrf_sram_bank.sv
`timescale 1ns/100ps

module vrf_sram_bank (
  input  logic           clk_i,
  // Single access port
  input  logic           req_i,
  input  logic           we_i,
  input  vrf_pkg::row_t  addr_i,
  input  vrf_pkg::elen_t wdata_i,
  input  vrf_pkg::strb_t be_i,
  // Read data, one cycle after the request
  output vrf_pkg::elen_t rdata_o
);

  import vrf_pkg::*;

  // Behavioral storage array
  elen_t mem_q [BankWords];

  // Byte-masked write path
  always_ff @(posedge clk_i) begin : p_write
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        // Only enabled bytes change
        if (be_i[b]) begin
          mem_q[addr_i][b*ByteWidth +: ByteWidth] <= wdata_i[b*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Registered read port
  // Holds the last word while no read is issued
  always_ff @(posedge clk_i) begin : p_read
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule : vrf_sram_bank

// File: vrf_operand_xbar.sv
`timescale 1ns/100ps

module vrf_operand_xbar (
  // One input per bank
  input  vrf_pkg::elen_t    [vrf_pkg::NrBanks-1:0]         data_i,
  input  logic              [vrf_pkg::NrBanks-1:0]         valid_i,
  input  vrf_pkg::opqueue_e [vrf_pkg::NrBanks-1:0]         sel_i,
  // One output per operand queue
  output vrf_pkg::elen_t    [vrf_pkg::NrOperandQueues-1:0] data_o,
  output logic              [vrf_pkg::NrOperandQueues-1:0] valid_o
);

  import vrf_pkg::*;

  // Per-bank one-hot of the targeted queue
  logic [NrBanks-1:0][NrOperandQueues-1:0] hit;

  // Decode the select of every valid bank
  always_comb begin : p_decode
    for (int unsigned b = 0; b < NrBanks; b++) begin
      for (int unsigned q = 0; q < NrOperandQueues; q++) begin
        hit[b][q] = valid_i[b] && (sel_i[b] == opqueue_e'(q));
      end
    end
  end

  // AND-OR merge
  // A queue has one read in flight, so at most one bank hits it
  always_comb begin : p_merge
    data_o  = '0;
    valid_o = '0;
    for (int unsigned q = 0; q < NrOperandQueues; q++) begin
      for (int unsigned b = 0; b < NrBanks; b++) begin
        if (hit[b][q]) begin
          data_o[q]  = data_o[q] | data_i[b];
          valid_o[q] = 1'b1;
        end
      end
    end
  end

endmodule : vrf_operand_xbar

// File: vrf_bank_arbiter.sv
`timescale 1ns/100ps

module vrf_bank_arbiter (
  // Read requesters, one per operand queue
  input  vrf_pkg::opq_req_t  [vrf_pkg::NrOperandQueues-1:0] opq_req_i,
  // Vector write port
  input  vrf_pkg::wr_req_t                                   wr_req_i,
  // Grant strobes, same cycle as the request
  output logic               [vrf_pkg::NrOperandQueues-1:0] opq_gnt_o,
  output logic                                               wr_gnt_o,
  // Per-bank access toward the register file
  output vrf_pkg::bank_req_t [vrf_pkg::NrBanks-1:0]         bank_req_o
);

  import vrf_pkg::*;

  // Decoded bank and row of every requester
  bank_idx_t [NrOperandQueues-1:0] opq_bank;
  row_t      [NrOperandQueues-1:0] opq_row;
  bank_idx_t                       wr_bank;
  row_t                            wr_row;

  // Word-interleaved split of the address
  always_comb begin : p_decode
    for (int unsigned q = 0; q < NrOperandQueues; q++) begin
      opq_bank[q] = opq_req_i[q].addr[BankSelWidth-1:0];
      opq_row[q]  = opq_req_i[q].addr[VaddrWidth-1:BankSelWidth];
    end
    wr_bank = wr_req_i.addr[BankSelWidth-1:0];
    wr_row  = wr_req_i.addr[VaddrWidth-1:BankSelWidth];
  end

  // The single write port always wins its bank
  assign wr_gnt_o = wr_req_i.req;

  // Per-bank selection
  // Write first, then the lowest queue index that maps here
  always_comb begin : p_arbiter
    opq_gnt_o = '0;
    for (int unsigned b = 0; b < NrBanks; b++) begin
      // Idle bank by default
      bank_req_o[b]     = '0;
      bank_req_o[b].tgt = OPQ_A;

      if (wr_req_i.req && (wr_bank == bank_idx_t'(b))) begin
        // Write access, target queue is a don't care
        bank_req_o[b].req   = 1'b1;
        bank_req_o[b].wen   = 1'b1;
        bank_req_o[b].row   = wr_row;
        bank_req_o[b].wdata = wr_req_i.wdata;
        bank_req_o[b].be    = wr_req_i.be;
      end else begin
        for (int unsigned q = 0; q < NrOperandQueues; q++) begin
          // First matching queue takes the bank
          if (!bank_req_o[b].req && opq_req_i[q].req &&
              (opq_bank[q] == bank_idx_t'(b))) begin
            bank_req_o[b].req = 1'b1;
            bank_req_o[b].row = opq_row[q];
            bank_req_o[b].tgt = opqueue_e'(q);
            opq_gnt_o[q]      = 1'b1;
          end
        end
      end
    end
  end

endmodule : vrf_bank_arbiter

// File: vector_regfile.sv
`timescale 1ns/100ps

module vector_regfile (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // Arbitrated bank accesses
  input  vrf_pkg::bank_req_t [vrf_pkg::NrBanks-1:0]            bank_req_i,
  // Operands toward the queues
  output vrf_pkg::elen_t     [vrf_pkg::NrOperandQueues-1:0]    operand_o,
  output logic               [vrf_pkg::NrOperandQueues-1:0]    operand_valid_o
);

  import vrf_pkg::*;

  // Raw bank outputs
  elen_t    [NrBanks-1:0] rdata;
  // Read strobe and target, aligned with the bank latency
  logic     [NrBanks-1:0] rdata_valid_q;
  opqueue_e [NrBanks-1:0] tgt_opqueue_q;

  // One-cycle delay of the read request
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rdata_valid
    if (!rst_ni) begin
      rdata_valid_q <= '0;
      for (int unsigned b = 0; b < NrBanks; b++) begin
        tgt_opqueue_q[b] <= OPQ_A;
      end
    end else begin
      for (int unsigned b = 0; b < NrBanks; b++) begin
        // Only reads produce an operand
        rdata_valid_q[b] <= bank_req_i[b].req & ~bank_req_i[b].wen;
        tgt_opqueue_q[b] <= bank_req_i[b].tgt;
      end
    end
  end

  // Word-interleaved banks
  for (genvar bank = 0; bank < NrBanks; bank++) begin : gen_banks
    vrf_sram_bank i_bank (
      .clk_i  (clk_i                   ),
      .req_i  (bank_req_i[bank].req    ),
      .we_i   (bank_req_i[bank].wen    ),
      .addr_i (bank_req_i[bank].row    ),
      .wdata_i(bank_req_i[bank].wdata  ),
      .be_i   (bank_req_i[bank].be     ),
      .rdata_o(rdata[bank]             )
    );
  end : gen_banks

  // Steer each bank word to its queue
  vrf_operand_xbar i_vrf_xbar (
    .data_i (rdata          ),
    .valid_i(rdata_valid_q  ),
    .sel_i  (tgt_opqueue_q  ),
    .data_o (operand_o      ),
    .valid_o(operand_valid_o)
  );

endmodule : vector_regfile

// File: vrf_lane.sv
`timescale 1ns/100ps

module vrf_lane (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  // Operand queue read requests
  input  vrf_pkg::opq_req_t [vrf_pkg::NrOperandQueues-1:0]    opq_req_i,
  // Vector write port
  input  vrf_pkg::wr_req_t                                    wr_req_i,
  // Grants, combinational
  output logic              [vrf_pkg::NrOperandQueues-1:0]    opq_gnt_o,
  output logic                                                wr_gnt_o,
  // Operands, one cycle after the read grant
  output vrf_pkg::elen_t    [vrf_pkg::NrOperandQueues-1:0]    operand_o,
  output logic              [vrf_pkg::NrOperandQueues-1:0]    operand_valid_o
);

  import vrf_pkg::*;

  // Arbitrated access of every bank
  bank_req_t [NrBanks-1:0] bank_req;

  // Bank conflict resolution
  vrf_bank_arbiter i_arbiter (
    .opq_req_i (opq_req_i),
    .wr_req_i  (wr_req_i ),
    .opq_gnt_o (opq_gnt_o),
    .wr_gnt_o  (wr_gnt_o ),
    .bank_req_o(bank_req )
  );

  // Banks, read delay and crossbar
  vector_regfile i_vrf (
    .clk_i          (clk_i          ),
    .rst_ni         (rst_ni         ),
    .bank_req_i     (bank_req       ),
    .operand_o      (operand_o      ),
    .operand_valid_o(operand_valid_o)
  );

endmodule : vrf_lane

// File: vrf_lane_props.sv
`timescale 1ns/100ps

module vrf_lane_props (
  input logic                                            clk_i,
  input logic                                            rst_ni,
  input vrf_pkg::opq_req_t [vrf_pkg::NrOperandQueues-1:0] opq_req_i,
  input vrf_pkg::wr_req_t                                wr_req_i,
  input logic              [vrf_pkg::NrOperandQueues-1:0] opq_gnt_o,
  input logic                                            wr_gnt_o,
  input logic              [vrf_pkg::NrOperandQueues-1:0] operand_valid_o
);

  import vrf_pkg::*;

  // Two grants landing on one bank
  logic bank_clash;

  always_comb begin : p_bank_clash
    bank_clash = 1'b0;
    for (int unsigned i = 0; i < NrOperandQueues; i++) begin
      if (opq_gnt_o[i] && wr_gnt_o &&
          (opq_req_i[i].addr[BankSelWidth-1:0] == wr_req_i.addr[BankSelWidth-1:0])) begin
        bank_clash = 1'b1;
      end
      for (int unsigned j = i + 1; j < NrOperandQueues; j++) begin
        if (opq_gnt_o[i] && opq_gnt_o[j] &&
            (opq_req_i[i].addr[BankSelWidth-1:0] == opq_req_i[j].addr[BankSelWidth-1:0])) begin
          bank_clash = 1'b1;
        end
      end
    end
  end

  // Read grant to operand valid, exactly one cycle
  for (genvar q = 0; q < NrOperandQueues; q++) begin : gen_read_latency
    a_read_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
      opq_gnt_o[q] |=> operand_valid_o[q])
      else $error("queue %0d granted without an operand one cycle later", q);
  end

  a_one_per_bank : assert property (@(posedge clk_i) disable iff (!rst_ni) !bank_clash)
    else $error("two grants on one bank in the same cycle");

  // Quiet outputs in reset and on the first cycle out of it
  a_reset_idle : assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> (opq_gnt_o == '0 && !wr_gnt_o && operand_valid_o == '0))
    else $error("grant or operand valid high around reset");

endmodule : vrf_lane_props

bind vrf_lane vrf_lane_props i_props (.*);

// File: vrf_lane_tb.sv
`timescale 1ns/100ps

module vrf_lane_tb;

  import vrf_pkg::*;

  // Operation counts per phase
  localparam int FillOps  = 256;
  localparam int ReadOps  = 32 * NrOperandQueues;
  localparam int PartOps  = 64;
  localparam int DirOps   = 2 * NrOperandQueues + 2;
  localparam int MixOps   = 400;
  localparam int NumOps   = FillOps + ReadOps + PartOps + DirOps + MixOps;
  localparam int MaxCycles = NumOps * 8 + 200;

  logic                                 clk;
  logic                                 rst_n;
  opq_req_t [NrOperandQueues-1:0]       opq_req;
  wr_req_t                              wr_req;
  logic     [NrOperandQueues-1:0]       opq_gnt;
  logic                                 wr_gnt;
  elen_t    [NrOperandQueues-1:0]       operand;
  logic     [NrOperandQueues-1:0]       operand_valid;

  integer seed = 32'hd93716c9;

  // Reference memory and the expected operand of the next cycle
  elen_t                        ref_mem [256];
  elen_t                        exp_operand [NrOperandQueues];
  logic [NrOperandQueues-1:0]   exp_valid;
  int unsigned                  grant_cnt [NrOperandQueues];
  int unsigned                  recv_cnt [NrOperandQueues];

  // Grants seen in the last cycle, used by the requesters
  logic [NrOperandQueues-1:0]   gnt_seen;
  logic                         wr_gnt_seen;

  // Pending work of every requester
  vaddr_t                       rd_list [NrOperandQueues][$];
  wr_req_t                      wr_list [$];

  int unsigned num_checks;
  int unsigned mismatches;
  int unsigned other_errors;

  vrf_lane dut_i (
    .clk_i          (clk          ),
    .rst_ni         (rst_n        ),
    .opq_req_i      (opq_req      ),
    .wr_req_i       (wr_req       ),
    .opq_gnt_o      (opq_gnt      ),
    .wr_gnt_o       (wr_gnt       ),
    .operand_o      (operand      ),
    .operand_valid_o(operand_valid)
  );

  // 20 ns clock
  initial begin : p_clock
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic elen_t rand_elen();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  // Byte-enable merge as seen by a reader
  function automatic elen_t merge_bytes(elen_t old_w, elen_t new_w, strb_t be);
    elen_t res;
    res = old_w;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic queue_read(input int q, input vaddr_t addr);
    rd_list[q].push_back(addr);
  endtask

  task automatic queue_write(input vaddr_t addr, input elen_t data, input strb_t be);
    wr_req_t w;
    w.req   = 1'b1;
    w.addr  = addr;
    w.wdata = data;
    w.be    = be;
    wr_list.push_back(w);
  endtask

  // Requesters hold a request until granted, then take the next one
  task automatic run_traffic(output logic [NrOperandQueues:0] first_gnt);
    int unsigned cyc;
    logic        busy;
    cyc       = 0;
    first_gnt = '0;
    do begin
      @(posedge clk);
      #2;
      // Grants of the first driven cycle
      if (cyc == 1) first_gnt = {wr_gnt_seen, gnt_seen};
      busy = 1'b0;
      for (int q = 0; q < NrOperandQueues; q++) begin
        if (!opq_req[q].req || gnt_seen[q]) begin
          if (rd_list[q].size() > 0) begin
            opq_req[q].req  = 1'b1;
            opq_req[q].addr = rd_list[q].pop_front();
          end else begin
            opq_req[q] = '0;
          end
        end
        busy = busy | opq_req[q].req;
      end
      if (!wr_req.req || wr_gnt_seen) begin
        if (wr_list.size() > 0) wr_req = wr_list.pop_front();
        else wr_req = '0;
      end
      busy = busy | wr_req.req;
      cyc++;
    end while (busy);
    // Last operands still in flight
    repeat (2) @(posedge clk);
  endtask

  task automatic check_grants(input logic [NrOperandQueues:0] got,
                              input logic [NrOperandQueues:0] exp, input string what);
    num_checks++;
    assert (got == exp) else begin
      mismatches++;
      $display("mismatch at %0t: %s granted %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Model, sampled mid-cycle where inputs and grants are settled
  always @(negedge clk) begin : p_model
    logic [NrBanks-1:0]         bank_busy;
    logic [NrOperandQueues-1:0] gnt_model;
    logic                       wr_gnt_model;
    bank_idx_t                  bk;
    if (!rst_n) begin
      exp_valid   = '0;
      gnt_seen    = '0;
      wr_gnt_seen = 1'b0;
    end else begin
      // Operands of reads granted one cycle ago
      for (int q = 0; q < NrOperandQueues; q++) begin
        num_checks++;
        assert (operand_valid[q] == exp_valid[q]) else begin
          mismatches++;
          $display("mismatch at %0t: queue %0d valid %b, expected %b",
                   $time, q, operand_valid[q], exp_valid[q]);
        end
        if (operand_valid[q]) recv_cnt[q]++;
        if (operand_valid[q] && exp_valid[q]) begin
          num_checks++;
          assert (operand[q] == exp_operand[q]) else begin
            mismatches++;
            $display("mismatch at %0t: queue %0d operand %h, expected %h",
                     $time, q, operand[q], exp_operand[q]);
          end
        end
      end
      // Write first, then lowest queue per bank
      bank_busy    = '0;
      gnt_model    = '0;
      wr_gnt_model = wr_req.req;
      if (wr_req.req) begin
        bk            = wr_req.addr[BankSelWidth-1:0];
        bank_busy[bk] = 1'b1;
      end
      for (int q = 0; q < NrOperandQueues; q++) begin
        bk = opq_req[q].addr[BankSelWidth-1:0];
        if (opq_req[q].req && !bank_busy[bk]) begin
          gnt_model[q]  = 1'b1;
          bank_busy[bk] = 1'b1;
        end
      end
      num_checks++;
      assert ({wr_gnt, opq_gnt} == {wr_gnt_model, gnt_model}) else begin
        mismatches++;
        $display("mismatch at %0t: grants %b, expected %b",
                 $time, {wr_gnt, opq_gnt}, {wr_gnt_model, gnt_model});
      end
      // Expected operands after the coming edge
      exp_valid = gnt_model;
      for (int q = 0; q < NrOperandQueues; q++) begin
        if (gnt_model[q]) begin
          exp_operand[q] = ref_mem[opq_req[q].addr];
          grant_cnt[q]++;
        end
      end
      if (wr_gnt_model) begin
        ref_mem[wr_req.addr] = merge_bytes(ref_mem[wr_req.addr], wr_req.wdata, wr_req.be);
      end
      gnt_seen    = opq_gnt;
      wr_gnt_seen = wr_gnt;
    end
  end

  initial begin : p_main
    logic [NrOperandQueues:0] first_gnt;
    logic [31:0]              rnd;
    vaddr_t                   part_addr [$];
    rst_n        = 1'b0;
    opq_req      = '0;
    wr_req       = '0;
    num_checks   = 0;
    mismatches   = 0;
    other_errors = 0;
    for (int q = 0; q < NrOperandQueues; q++) begin
      grant_cnt[q] = 0;
      recv_cnt[q]  = 0;
    end
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;

    // Idle outputs right after reset
    @(negedge clk);
    num_checks++;
    assert (opq_gnt == '0 && !wr_gnt && operand_valid == '0) else begin
      other_errors++;
      $display("a grant or operand valid is high right after reset");
    end

    // Fill every word with a full mask
    for (int a = 0; a < FillOps; a++) queue_write(vaddr_t'(a), rand_elen(), '1);
    run_traffic(first_gnt);

    // Random reads from all queues
    for (int i = 0; i < ReadOps; i++) begin
      rnd = $random(seed);
      queue_read(i % NrOperandQueues, rnd[7:0]);
    end
    run_traffic(first_gnt);

    // Partial byte-enable writes, then read back
    for (int i = 0; i < PartOps / 2; i++) begin
      rnd = $random(seed);
      part_addr.push_back(rnd[7:0]);
      queue_write(rnd[7:0], rand_elen(), rnd[15:8]);
    end
    run_traffic(first_gnt);
    for (int i = 0; i < PartOps / 2; i++) queue_read(i % NrOperandQueues, part_addr[i]);
    run_traffic(first_gnt);

    // All queues on bank 1, only queue A wins at first
    for (int q = 0; q < NrOperandQueues; q++) queue_read(q, vaddr_t'(4 * q + 1));
    run_traffic(first_gnt);
    check_grants(first_gnt, 5'b00001, "same-bank reads");
    // One queue per bank, all granted together
    for (int q = 0; q < NrOperandQueues; q++) queue_read(q, vaddr_t'(16 + q));
    run_traffic(first_gnt);
    check_grants(first_gnt, 5'b01111, "different-bank reads");

    // Write and read on bank 2 in one cycle
    queue_write(8'h22, rand_elen(), '1);
    queue_read(1, 8'h22);
    run_traffic(first_gnt);
    check_grants(first_gnt, 5'b10000, "write against read");

    // Long mixed phase
    for (int i = 0; i < MixOps; i++) begin
      rnd = $random(seed);
      if (rnd[0]) queue_write(rnd[15:8], rand_elen(), rnd[23:16]);
      else queue_read(int'(rnd[2:1]), rnd[15:8]);
    end
    run_traffic(first_gnt);

    // Every grant delivered exactly one operand
    for (int q = 0; q < NrOperandQueues; q++) begin
      num_checks++;
      assert (recv_cnt[q] == grant_cnt[q]) else begin
        mismatches++;
        $display("mismatch at %0t: queue %0d received %0d operands for %0d grants",
                 $time, q, recv_cnt[q], grant_cnt[q]);
      end
    end

    $display("checks %0d, mismatches %0d, other errors %0d",
             num_checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Cycle budget scales with the operation count
  initial begin : p_watchdog
    repeat (MaxCycles) @(posedge clk);
    $display("timeout: traffic did not drain within %0d cycles", MaxCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule : vrf_lane_tb

// File: vrf_lane.f
vrf_pkg.sv
vrf_sram_bank.sv
vrf_operand_xbar.sv
vrf_bank_arbiter.sv
vector_regfile.sv
vrf_lane.sv
vrf_lane_props.sv
vrf_lane_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the lane testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module vrf_lane_tb \
  -f vrf_lane.f

# A failing assertion may end the run with a nonzero status
status=0
output=$(./obj_dir/Vvrf_lane_tb) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx 'TEST OK'; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
